// ==== hdl/rv_id_consts.svh ====
// shared widths and register numbers for the decode stage, `include wherever a width is needed
`ifndef RV_ID_CONSTS_SVH
`define RV_ID_CONSTS_SVH

// data and address width
`define XLEN 32

// register number width
`define REG_ADDR_W 5

// instruction word width
`define INST_W 32

// x0, hardwired zero
`define ZERO_REG {`REG_ADDR_W{1'b0}}

`endif

// ==== hdl/rv_isa_pkg.sv ====
// RV32I encoding types, imported by the decoder and the testbench to name opcodes and funct3 codes
package rv_isa_pkg;

    // major opcodes, bits [6:0]
    typedef enum logic [6:0] {
        OPC_LUI      = 7'b0110111,
        OPC_AUIPC    = 7'b0010111,
        OPC_JAL      = 7'b1101111,
        OPC_JALR     = 7'b1100111,
        OPC_BRANCH   = 7'b1100011,
        OPC_LOAD     = 7'b0000011,
        OPC_STORE    = 7'b0100011,
        OPC_OP_IMM   = 7'b0010011,
        OPC_OP       = 7'b0110011,
        OPC_MISC_MEM = 7'b0001111,  // fence, not decoded
        OPC_SYSTEM   = 7'b1110011   // csr, not decoded
    } opcode_e;

    // branch
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // load
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    // store
    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    // immediate alu
    localparam logic [2:0] F3_ADDI  = 3'b000;
    localparam logic [2:0] F3_SLLI  = 3'b001;
    localparam logic [2:0] F3_SLTI  = 3'b010;
    localparam logic [2:0] F3_SLTIU = 3'b011;
    localparam logic [2:0] F3_XORI  = 3'b100;
    localparam logic [2:0] F3_SRI   = 3'b101;  // srli and srai
    localparam logic [2:0] F3_ORI   = 3'b110;
    localparam logic [2:0] F3_ANDI  = 3'b111;

    // register alu
    localparam logic [2:0] F3_ADD  = 3'b000;   // add and sub
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;   // srl and sra
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

endpackage

// ==== hdl/rv_exec_pkg.sv ====
// execute-side control types shared by decode, the pipeline register and the checker
package rv_exec_pkg;

    // operation handed to execute
    typedef enum logic [4:0] {
        OP_NONE,
        OP_ADD,
        OP_SUB,
        OP_SLT,
        OP_SLTU,
        OP_XOR,
        OP_OR,
        OP_AND,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_LUI,
        OP_JAL,
        OP_JALR,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_LB,
        OP_LH,
        OP_LW,
        OP_LBU,
        OP_LHU,
        OP_SB,
        OP_SH,
        OP_SW
    } aluop_e;

    // result class, picks the execute result mux
    typedef enum logic [2:0] {
        RES_NONE,
        RES_LOGIC,
        RES_SHIFT,
        RES_ARITH,
        RES_COMPARE,
        RES_BRANCH,
        RES_LOAD,
        RES_STORE
    } alusel_e;

    // data only available after mem
    function automatic logic is_load(aluop_e op);
        return op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    endfunction

endpackage

// ==== hdl/inst_decoder.sv ====
// combinational RV32I decoder, turns one instruction into register reads, immediates and controls
`timescale 1ns/1ps

`include "rv_id_consts.svh"

module inst_decoder import rv_isa_pkg::*; import rv_exec_pkg::*; (
    input  logic [`XLEN-1:0]       pc_i,
    input  logic [`INST_W-1:0]     inst_i,
    output logic                   reg1_read_o,
    output logic                   reg2_read_o,
    output logic [`REG_ADDR_W-1:0] reg1_addr_o,
    output logic [`REG_ADDR_W-1:0] reg2_addr_o,
    output logic [`XLEN-1:0]       imm1_o,
    output logic [`XLEN-1:0]       imm2_o,
    output aluop_e                 aluop_o,
    output alusel_e                alusel_o,
    output logic                   wreg_o,
    output logic [`REG_ADDR_W-1:0] wreg_addr_o,
    output logic                   inst_valid_o
);

    opcode_e                opcode;
    logic [`REG_ADDR_W-1:0] rd;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`XLEN-1:0]       imm_u;
    logic [`XLEN-1:0]       imm_i;
    logic [`XLEN-1:0]       imm_sh;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];

    assign imm_u  = {inst_i[31:12], 12'b0};
    assign imm_i  = {{(`XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_sh = {{(`XLEN-5){1'b0}}, inst_i[24:20]};  // shamt

    // result class of an alu-type op
    function automatic alusel_e alu_class(aluop_e op);
        case (op)
            OP_ADD, OP_SUB:         return RES_ARITH;
            OP_SLT, OP_SLTU:        return RES_COMPARE;
            OP_SLL, OP_SRL, OP_SRA: return RES_SHIFT;
            default:                return RES_LOGIC;
        endcase
    endfunction

    always_comb begin
        aluop_o      = OP_NONE;
        alusel_o     = RES_NONE;
        wreg_o       = 1'b0;
        wreg_addr_o  = rd;
        reg1_read_o  = 1'b0;
        reg2_read_o  = 1'b0;
        reg1_addr_o  = rs1;
        reg2_addr_o  = rs2;
        imm1_o       = '0;
        imm2_o       = '0;
        inst_valid_o = 1'b0;

        case (opcode)
            OPC_LUI: begin
                aluop_o      = OP_LUI;
                alusel_o     = RES_SHIFT;
                wreg_o       = 1'b1;
                imm2_o       = imm_u;
                inst_valid_o = 1'b1;
            end
            OPC_AUIPC: begin
                aluop_o      = OP_ADD;
                alusel_o     = RES_ARITH;
                wreg_o       = 1'b1;
                imm1_o       = pc_i;
                imm2_o       = imm_u;
                inst_valid_o = 1'b1;
            end
            OPC_JAL: begin
                aluop_o      = OP_JAL;
                alusel_o     = RES_BRANCH;
                wreg_o       = 1'b1;
                inst_valid_o = 1'b1;
            end
            OPC_JALR: begin
                aluop_o      = OP_JALR;
                alusel_o     = RES_BRANCH;
                wreg_o       = 1'b1;
                reg1_read_o  = 1'b1;
                inst_valid_o = 1'b1;
            end
            OPC_BRANCH: begin
                case (funct3)
                    F3_BEQ:  aluop_o = OP_BEQ;
                    F3_BNE:  aluop_o = OP_BNE;
                    F3_BLT:  aluop_o = OP_BLT;
                    F3_BGE:  aluop_o = OP_BGE;
                    F3_BLTU: aluop_o = OP_BLTU;
                    F3_BGEU: aluop_o = OP_BGEU;
                    default: aluop_o = OP_NONE;
                endcase
                if (aluop_o != OP_NONE) begin
                    reg1_read_o  = 1'b1;
                    reg2_read_o  = 1'b1;
                    inst_valid_o = 1'b1;
                end
            end
            OPC_LOAD: begin
                case (funct3)
                    F3_LB:   aluop_o = OP_LB;
                    F3_LH:   aluop_o = OP_LH;
                    F3_LW:   aluop_o = OP_LW;
                    F3_LBU:  aluop_o = OP_LBU;
                    F3_LHU:  aluop_o = OP_LHU;
                    default: aluop_o = OP_NONE;
                endcase
                if (aluop_o != OP_NONE) begin
                    alusel_o     = RES_LOAD;
                    wreg_o       = 1'b1;
                    reg1_read_o  = 1'b1;  // base address
                    inst_valid_o = 1'b1;
                end
            end
            OPC_STORE: begin
                case (funct3)
                    F3_SB:   aluop_o = OP_SB;
                    F3_SH:   aluop_o = OP_SH;
                    F3_SW:   aluop_o = OP_SW;
                    default: aluop_o = OP_NONE;
                endcase
                if (aluop_o != OP_NONE) begin
                    alusel_o     = RES_STORE;
                    reg1_read_o  = 1'b1;
                    reg2_read_o  = 1'b1;  // store data
                    inst_valid_o = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                case (funct3)
                    F3_ADDI:  aluop_o = OP_ADD;
                    F3_SLTI:  aluop_o = OP_SLT;
                    F3_SLTIU: aluop_o = OP_SLTU;
                    F3_XORI:  aluop_o = OP_XOR;
                    F3_ORI:   aluop_o = OP_OR;
                    F3_ANDI:  aluop_o = OP_AND;
                    F3_SLLI:  aluop_o = OP_SLL;
                    default:  aluop_o = inst_i[30] ? OP_SRA : OP_SRL;
                endcase
                alusel_o     = alu_class(aluop_o);
                wreg_o       = 1'b1;
                reg1_read_o  = 1'b1;
                imm2_o       = (alusel_o == RES_SHIFT) ? imm_sh : imm_i;
                inst_valid_o = 1'b1;
            end
            OPC_OP: begin
                if (!inst_i[25]) begin  // bit 25 set is the m-extension
                    case (funct3)
                        F3_ADD:  aluop_o = inst_i[30] ? OP_SUB : OP_ADD;
                        F3_SLL:  aluop_o = OP_SLL;
                        F3_SLT:  aluop_o = OP_SLT;
                        F3_SLTU: aluop_o = OP_SLTU;
                        F3_XOR:  aluop_o = OP_XOR;
                        F3_SRL:  aluop_o = inst_i[30] ? OP_SRA : OP_SRL;
                        F3_OR:   aluop_o = OP_OR;
                        default: aluop_o = OP_AND;
                    endcase
                    alusel_o     = alu_class(aluop_o);
                    wreg_o       = 1'b1;
                    reg1_read_o  = 1'b1;
                    reg2_read_o  = 1'b1;
                    inst_valid_o = 1'b1;
                end
            end
            default: begin
                inst_valid_o = 1'b0;  // fence, system and unknown opcodes
            end
        endcase
    end

endmodule

// ==== hdl/operand_select.sv ====
// picks one source operand with execute/memory forwarding and flags a load-use hazard
`timescale 1ns/1ps

`include "rv_id_consts.svh"

module operand_select import rv_exec_pkg::*; (
    input  logic                   read_i,
    input  logic [`REG_ADDR_W-1:0] addr_i,
    input  logic [`XLEN-1:0]       imm_i,
    input  logic [`XLEN-1:0]       reg_data_i,
    input  logic                   ex_wreg_i,
    input  logic [`REG_ADDR_W-1:0] ex_wreg_addr_i,
    input  logic [`XLEN-1:0]       ex_wreg_data_i,
    input  aluop_e                 ex_aluop_i,
    input  logic                   mem_wreg_i,
    input  logic [`REG_ADDR_W-1:0] mem_wreg_addr_i,
    input  logic [`XLEN-1:0]       mem_wreg_data_i,
    output logic [`XLEN-1:0]       operand_o,
    output logic                   stall_o
);

    logic ex_hit;
    logic mem_hit;

    assign ex_hit  = (ex_wreg_addr_i == addr_i);
    assign mem_hit = mem_wreg_i && (mem_wreg_addr_i == addr_i);

    always_comb begin
        stall_o = 1'b0;
        if (!read_i) begin
            operand_o = imm_i;
        end else if (addr_i == `ZERO_REG) begin
            operand_o = '0;
        end else if (is_load(ex_aluop_i) && ex_hit) begin
            // load result not ready until mem, hold one cycle
            operand_o = '0;
            stall_o   = 1'b1;
        end else if (ex_wreg_i && ex_hit) begin
            operand_o = ex_wreg_data_i;  // youngest result wins
        end else if (mem_hit) begin
            operand_o = mem_wreg_data_i;
        end else begin
            operand_o = reg_data_i;
        end
    end

endmodule

// ==== hdl/id_ex_reg.sv ====
// decode-to-execute pipeline register, loads a bubble while decode is stalled
`timescale 1ns/1ps

`include "rv_id_consts.svh"

module id_ex_reg import rv_exec_pkg::*; (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   stall_i,
    input  logic [`XLEN-1:0]       pc_i,
    input  logic [`INST_W-1:0]     inst_i,
    input  aluop_e                 aluop_i,
    input  alusel_e                alusel_i,
    input  logic [`XLEN-1:0]       operand1_i,
    input  logic [`XLEN-1:0]       operand2_i,
    input  logic                   wreg_i,
    input  logic [`REG_ADDR_W-1:0] wreg_addr_i,
    input  logic                   inst_valid_i,
    output logic [`XLEN-1:0]       ex_pc_o,
    output logic [`INST_W-1:0]     ex_inst_o,
    output aluop_e                 ex_aluop_o,
    output alusel_e                ex_alusel_o,
    output logic [`XLEN-1:0]       ex_operand1_o,
    output logic [`XLEN-1:0]       ex_operand2_o,
    output logic                   ex_wreg_o,
    output logic [`REG_ADDR_W-1:0] ex_wreg_addr_o,
    output logic                   ex_inst_valid_o
);

    always_ff @(posedge clk) begin
        if (reset_i || stall_i) begin  // stall pushes a nop into execute
            ex_pc_o         <= '0;
            ex_inst_o       <= '0;
            ex_aluop_o      <= OP_NONE;
            ex_alusel_o     <= RES_NONE;
            ex_operand1_o   <= '0;
            ex_operand2_o   <= '0;
            ex_wreg_o       <= 1'b0;
            ex_wreg_addr_o  <= `ZERO_REG;
            ex_inst_valid_o <= 1'b0;
        end else begin
            ex_pc_o         <= pc_i;
            ex_inst_o       <= inst_i;
            ex_aluop_o      <= aluop_i;
            ex_alusel_o     <= alusel_i;
            ex_operand1_o   <= operand1_i;
            ex_operand2_o   <= operand2_i;
            ex_wreg_o       <= wreg_i;
            ex_wreg_addr_o  <= wreg_addr_i;
            ex_inst_valid_o <= inst_valid_i;
        end
    end

endmodule

// ==== hdl/rv_id_top.sv ====
// decode stage top, connects decoder, both operand selectors and the id/ex register
`timescale 1ns/1ps

`include "rv_id_consts.svh"

module rv_id_top import rv_exec_pkg::*; (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic [`XLEN-1:0]       pc_i,
    input  logic [`INST_W-1:0]     inst_i,
    input  logic [`XLEN-1:0]       reg1_data_i,
    input  logic [`XLEN-1:0]       reg2_data_i,
    input  logic                   ex_wreg_i,
    input  logic [`REG_ADDR_W-1:0] ex_wreg_addr_i,
    input  logic [`XLEN-1:0]       ex_wreg_data_i,
    input  aluop_e                 ex_aluop_i,
    input  logic                   mem_wreg_i,
    input  logic [`REG_ADDR_W-1:0] mem_wreg_addr_i,
    input  logic [`XLEN-1:0]       mem_wreg_data_i,
    output logic                   reg1_read_o,
    output logic                   reg2_read_o,
    output logic [`REG_ADDR_W-1:0] reg1_addr_o,
    output logic [`REG_ADDR_W-1:0] reg2_addr_o,
    output logic                   stall_o,
    output logic [`XLEN-1:0]       ex_pc_o,
    output logic [`INST_W-1:0]     ex_inst_o,
    output aluop_e                 ex_aluop_o,
    output alusel_e                ex_alusel_o,
    output logic [`XLEN-1:0]       ex_operand1_o,
    output logic [`XLEN-1:0]       ex_operand2_o,
    output logic                   ex_wreg_o,
    output logic [`REG_ADDR_W-1:0] ex_wreg_addr_o,
    output logic                   ex_inst_valid_o
);

    logic [`XLEN-1:0]       imm1;
    logic [`XLEN-1:0]       imm2;
    aluop_e                 aluop;
    alusel_e                alusel;
    logic                   wreg;
    logic [`REG_ADDR_W-1:0] wreg_addr;
    logic                   inst_valid;
    logic [`XLEN-1:0]       operand1;
    logic [`XLEN-1:0]       operand2;
    logic                   stall1;
    logic                   stall2;

    inst_decoder inst_decoder_i (
        .pc_i         (pc_i),
        .inst_i       (inst_i),
        .reg1_read_o  (reg1_read_o),
        .reg2_read_o  (reg2_read_o),
        .reg1_addr_o  (reg1_addr_o),
        .reg2_addr_o  (reg2_addr_o),
        .imm1_o       (imm1),
        .imm2_o       (imm2),
        .aluop_o      (aluop),
        .alusel_o     (alusel),
        .wreg_o       (wreg),
        .wreg_addr_o  (wreg_addr),
        .inst_valid_o (inst_valid)
    );

    operand_select sel1 (
        .read_i          (reg1_read_o),
        .addr_i          (reg1_addr_o),
        .imm_i           (imm1),
        .reg_data_i      (reg1_data_i),
        .ex_wreg_i       (ex_wreg_i),
        .ex_wreg_addr_i  (ex_wreg_addr_i),
        .ex_wreg_data_i  (ex_wreg_data_i),
        .ex_aluop_i      (ex_aluop_i),
        .mem_wreg_i      (mem_wreg_i),
        .mem_wreg_addr_i (mem_wreg_addr_i),
        .mem_wreg_data_i (mem_wreg_data_i),
        .operand_o       (operand1),
        .stall_o         (stall1)
    );

    operand_select sel2 (
        .read_i          (reg2_read_o),
        .addr_i          (reg2_addr_o),
        .imm_i           (imm2),
        .reg_data_i      (reg2_data_i),
        .ex_wreg_i       (ex_wreg_i),
        .ex_wreg_addr_i  (ex_wreg_addr_i),
        .ex_wreg_data_i  (ex_wreg_data_i),
        .ex_aluop_i      (ex_aluop_i),
        .mem_wreg_i      (mem_wreg_i),
        .mem_wreg_addr_i (mem_wreg_addr_i),
        .mem_wreg_data_i (mem_wreg_data_i),
        .operand_o       (operand2),
        .stall_o         (stall2)
    );

    // either source can hold the pipe
    assign stall_o = stall1 | stall2;

    id_ex_reg id_ex_reg_i (
        .clk             (clk),
        .reset_i         (reset_i),
        .stall_i         (stall_o),
        .pc_i            (pc_i),
        .inst_i          (inst_i),
        .aluop_i         (aluop),
        .alusel_i        (alusel),
        .operand1_i      (operand1),
        .operand2_i      (operand2),
        .wreg_i          (wreg),
        .wreg_addr_i     (wreg_addr),
        .inst_valid_i    (inst_valid),
        .ex_pc_o         (ex_pc_o),
        .ex_inst_o       (ex_inst_o),
        .ex_aluop_o      (ex_aluop_o),
        .ex_alusel_o     (ex_alusel_o),
        .ex_operand1_o   (ex_operand1_o),
        .ex_operand2_o   (ex_operand2_o),
        .ex_wreg_o       (ex_wreg_o),
        .ex_wreg_addr_o  (ex_wreg_addr_o),
        .ex_inst_valid_o (ex_inst_valid_o)
    );

endmodule

// ==== test/tb_clock_gen.sv ====
// testbench clock and reset source, 20 ns period with reset held for the first two cycles
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;  // released between edges
    end

endmodule

// ==== test/rv_id_checker.sv ====
// testbench checker, compares the decode stage outputs with the expected part of each vector
`timescale 1ns/1ps

`include "rv_id_consts.svh"

module rv_id_checker import rv_isa_pkg::*; import rv_exec_pkg::*; (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   check_i,     // a vector sits on the dut inputs
    input  int                     test_id_i,
    input  logic [95:0]            expect_i,
    input  logic [`XLEN-1:0]       pc_i,
    input  logic [`INST_W-1:0]     inst_i,
    input  logic                   reg1_read_i,
    input  logic                   reg2_read_i,
    input  logic [`REG_ADDR_W-1:0] reg1_addr_i,
    input  logic [`REG_ADDR_W-1:0] reg2_addr_i,
    input  logic                   stall_i,
    input  logic [`XLEN-1:0]       ex_pc_i,
    input  logic [`INST_W-1:0]     ex_inst_i,
    input  aluop_e                 ex_aluop_i,
    input  alusel_e                ex_alusel_i,
    input  logic                   ex_wreg_i,
    input  logic [`REG_ADDR_W-1:0] ex_wreg_addr_i,
    input  logic [`XLEN-1:0]       ex_operand1_i,
    input  logic [`XLEN-1:0]       ex_operand2_i,
    input  logic                   ex_inst_valid_i,
    output int                     pass_count_o,
    output int                     fail_count_o
);

    logic                   in_reset;
    logic                   armed;
    logic                   stall_seen;
    logic                   read1_seen;
    logic                   read2_seen;
    logic [`REG_ADDR_W-1:0] addr1_seen;
    logic [`REG_ADDR_W-1:0] addr2_seen;
    logic [`XLEN-1:0]       pc_q;
    logic [`INST_W-1:0]     inst_q;
    logic [95:0]            exp_q;
    int                     id_q;
    bit                     reset_checked = 1'b0;
    int                     pass_count = 0;
    int                     fail_count = 0;

    assign pass_count_o = pass_count;
    assign fail_count_o = fail_count;

    // rs1 is a source of jalr, branches, loads, stores and both alu forms
    function automatic logic rs1_used(input logic [6:0] opc);
        case (opc)
            OPC_JALR, OPC_BRANCH, OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // rs2 only for branches, stores and register alu
    function automatic logic rs2_used(input logic [6:0] opc);
        case (opc)
            OPC_BRANCH, OPC_STORE, OPC_OP: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic compare_field(input string name, input logic [31:0] expv,
                                 input logic [31:0] actv, inout bit ok);
        if (actv !== expv) begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, expv, actv);
            ok = 1'b0;
        end
    endtask

    task automatic finish_test(input string label, input bit ok);
        if (ok) begin
            pass_count++;
            $display("test %s ok", label);
        end else begin
            fail_count++;
            $display("test %s failed", label);
        end
    endtask

    task automatic check_reset();
        bit ok;
        ok = 1'b1;
        compare_field("ex_aluop_o", 32'(OP_NONE), 32'(ex_aluop_i), ok);
        compare_field("ex_wreg_o", 32'(1'b0), 32'(ex_wreg_i), ok);
        compare_field("ex_inst_valid_o", 32'(1'b0), 32'(ex_inst_valid_i), ok);
        finish_test("reset", ok);
    endtask

    task automatic check_vector();
        bit   ok;
        bit   decoded;
        logic exp_read1;
        logic exp_read2;
        ok        = 1'b1;
        decoded   = exp_q[0] | exp_q[92];  // a stalled instruction still decodes
        exp_read1 = decoded && rs1_used(inst_q[6:0]);
        exp_read2 = decoded && rs2_used(inst_q[6:0]);
        compare_field("stall_o", 32'(exp_q[92]), 32'(stall_seen), ok);
        compare_field("reg1_read_o", 32'(exp_read1), 32'(read1_seen), ok);
        compare_field("reg2_read_o", 32'(exp_read2), 32'(read2_seen), ok);
        if (exp_read1) begin
            compare_field("reg1_addr_o", 32'(inst_q[19:15]), 32'(addr1_seen), ok);
        end
        if (exp_read2) begin
            compare_field("reg2_addr_o", 32'(inst_q[24:20]), 32'(addr2_seen), ok);
        end
        compare_field("ex_pc_o", exp_q[92] ? 32'd0 : pc_q, ex_pc_i, ok);  // bubble clears pc
        compare_field("ex_inst_o", exp_q[92] ? 32'd0 : inst_q, ex_inst_i, ok);
        compare_field("ex_aluop_o", 32'(exp_q[88:84]), 32'(ex_aluop_i), ok);
        compare_field("ex_alusel_o", 32'(exp_q[82:80]), 32'(ex_alusel_i), ok);
        compare_field("ex_wreg_o", 32'(exp_q[76]), 32'(ex_wreg_i), ok);
        if (exp_q[76]) begin  // address means nothing without a write
            compare_field("ex_wreg_addr_o", 32'(exp_q[72:68]), 32'(ex_wreg_addr_i), ok);
        end
        compare_field("ex_operand1_o", exp_q[67:36], ex_operand1_i, ok);
        compare_field("ex_operand2_o", exp_q[35:4], ex_operand2_i, ok);
        compare_field("ex_inst_valid_o", 32'(exp_q[0]), 32'(ex_inst_valid_i), ok);
        finish_test($sformatf("%0d", id_q), ok);
    endtask

    // decode outputs are combinational on the inputs, take them at the capturing edge
    always @(posedge clk_i) begin
        in_reset <= reset_i;
        armed    <= check_i;
        if (check_i) begin
            exp_q      <= expect_i;
            id_q       <= test_id_i;
            pc_q       <= pc_i;
            inst_q     <= inst_i;
            stall_seen <= stall_i;
            read1_seen <= reg1_read_i;
            read2_seen <= reg2_read_i;
            addr1_seen <= reg1_addr_i;
            addr2_seen <= reg2_addr_i;
        end
    end

    // register outputs settle well before the falling edge
    always @(negedge clk_i) begin
        if (in_reset && !reset_checked) begin
            check_reset();
            reset_checked <= 1'b1;
        end else if (armed) begin
            check_vector();
        end
    end

endmodule

// ==== test/rv_id_tb.sv ====
// testbench top, reads the stimulus vectors, drives the decode stage and prints the verdict
`timescale 1ns/1ps

`include "rv_id_consts.svh"

module rv_id_tb import rv_exec_pkg::*; ();

    localparam int MAX_VECTORS = 64;
    localparam int VEC_W       = 320;

    logic                   clk;
    logic                   reset;
    logic [VEC_W-1:0]       vectors [MAX_VECTORS];
    int                     n_vectors;
    int                     cycles = 0;
    logic                   check_en;
    int                     test_id;
    logic [95:0]            expect_bits;
    int                     pass_count;
    int                     fail_count;

    logic [`XLEN-1:0]       pc;
    logic [`INST_W-1:0]     inst;
    logic [`XLEN-1:0]       reg1_data;
    logic [`XLEN-1:0]       reg2_data;
    logic                   ex_wreg;
    logic [`REG_ADDR_W-1:0] ex_wreg_addr;
    logic [`XLEN-1:0]       ex_wreg_data;
    aluop_e                 ex_aluop;
    logic                   mem_wreg;
    logic [`REG_ADDR_W-1:0] mem_wreg_addr;
    logic [`XLEN-1:0]       mem_wreg_data;

    logic                   reg1_read;
    logic                   reg2_read;
    logic [`REG_ADDR_W-1:0] reg1_addr;
    logic [`REG_ADDR_W-1:0] reg2_addr;
    logic                   stall;
    logic [`XLEN-1:0]       dut_ex_pc;
    logic [`INST_W-1:0]     dut_ex_inst;
    aluop_e                 dut_ex_aluop;
    alusel_e                dut_ex_alusel;
    logic [`XLEN-1:0]       dut_ex_operand1;
    logic [`XLEN-1:0]       dut_ex_operand2;
    logic                   dut_ex_wreg;
    logic [`REG_ADDR_W-1:0] dut_ex_wreg_addr;
    logic                   dut_ex_inst_valid;

    tb_clock_gen tb_clock_gen_i (
        .clk_o   (clk),
        .reset_o (reset)
    );

    rv_id_top rv_id_top_i (
        .clk             (clk),
        .reset_i         (reset),
        .pc_i            (pc),
        .inst_i          (inst),
        .reg1_data_i     (reg1_data),
        .reg2_data_i     (reg2_data),
        .ex_wreg_i       (ex_wreg),
        .ex_wreg_addr_i  (ex_wreg_addr),
        .ex_wreg_data_i  (ex_wreg_data),
        .ex_aluop_i      (ex_aluop),
        .mem_wreg_i      (mem_wreg),
        .mem_wreg_addr_i (mem_wreg_addr),
        .mem_wreg_data_i (mem_wreg_data),
        .reg1_read_o     (reg1_read),
        .reg2_read_o     (reg2_read),
        .reg1_addr_o     (reg1_addr),
        .reg2_addr_o     (reg2_addr),
        .stall_o         (stall),
        .ex_pc_o         (dut_ex_pc),
        .ex_inst_o       (dut_ex_inst),
        .ex_aluop_o      (dut_ex_aluop),
        .ex_alusel_o     (dut_ex_alusel),
        .ex_operand1_o   (dut_ex_operand1),
        .ex_operand2_o   (dut_ex_operand2),
        .ex_wreg_o       (dut_ex_wreg),
        .ex_wreg_addr_o  (dut_ex_wreg_addr),
        .ex_inst_valid_o (dut_ex_inst_valid)
    );

    rv_id_checker rv_id_checker_i (
        .clk_i           (clk),
        .reset_i         (reset),
        .check_i         (check_en),
        .test_id_i       (test_id),
        .expect_i        (expect_bits),
        .pc_i            (pc),
        .inst_i          (inst),
        .reg1_read_i     (reg1_read),
        .reg2_read_i     (reg2_read),
        .reg1_addr_i     (reg1_addr),
        .reg2_addr_i     (reg2_addr),
        .stall_i         (stall),
        .ex_pc_i         (dut_ex_pc),
        .ex_inst_i       (dut_ex_inst),
        .ex_aluop_i      (dut_ex_aluop),
        .ex_alusel_i     (dut_ex_alusel),
        .ex_wreg_i       (dut_ex_wreg),
        .ex_wreg_addr_i  (dut_ex_wreg_addr),
        .ex_operand1_i   (dut_ex_operand1),
        .ex_operand2_i   (dut_ex_operand2),
        .ex_inst_valid_i (dut_ex_inst_valid),
        .pass_count_o    (pass_count),
        .fail_count_o    (fail_count)
    );

    // field layout matches the column comment in the vector file
    task automatic apply_vector(input logic [VEC_W-1:0] v, input int idx);
        pc            = v[319:288];
        inst          = v[287:256];
        reg1_data     = v[255:224];
        reg2_data     = v[223:192];
        ex_wreg       = v[188];
        ex_wreg_addr  = v[184:180];
        ex_wreg_data  = v[179:148];
        ex_aluop      = aluop_e'(v[144:140]);
        mem_wreg      = v[136];
        mem_wreg_addr = v[132:128];
        mem_wreg_data = v[127:96];
        expect_bits   = v[95:0];
        test_id       = idx;
        check_en      = 1'b1;
    endtask

    // vectors plus reset and drain, with some slack
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > n_vectors + 10) begin
            $display("timeout after %0d cycles, checker did not finish", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        pc            = '0;
        inst          = '0;
        reg1_data     = '0;
        reg2_data     = '0;
        ex_wreg       = 1'b0;
        ex_wreg_addr  = '0;
        ex_wreg_data  = '0;
        ex_aluop      = OP_NONE;
        mem_wreg      = 1'b0;
        mem_wreg_addr = '0;
        mem_wreg_data = '0;
        check_en      = 1'b0;
        test_id       = 0;
        expect_bits   = '0;

        $readmemh("test/rv_id_stimulus.mem", vectors);
        n_vectors = 0;
        while (n_vectors < MAX_VECTORS && !$isunknown(vectors[n_vectors])) begin
            n_vectors++;
        end

        if (n_vectors == 0) begin
            $display("no vectors could be read from the stimulus file");
        end else begin
            @(negedge reset);
            for (int i = 0; i < n_vectors; i++) begin
                apply_vector(vectors[i], i);
                @(negedge clk);
            end
            check_en = 1'b0;
            while (pass_count + fail_count < n_vectors + 1) begin  // +1 for reset
                @(posedge clk);
            end
        end

        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0 && n_vectors > 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== rv_id.f ====
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_exec_pkg.sv
hdl/inst_decoder.sv
hdl/operand_select.sv
hdl/id_ex_reg.sv
hdl/rv_id_top.sv
test/tb_clock_gen.sv
test/rv_id_checker.sv
test/rv_id_tb.sv

// ==== Bender.yml ====
package:
  name: rv_id

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_isa_pkg.sv
      - hdl/rv_exec_pkg.sv
      - hdl/inst_decoder.sv
      - hdl/operand_select.sv
      - hdl/id_ex_reg.sv
      - hdl/rv_id_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/tb_clock_gen.sv
      - test/rv_id_checker.sv
      - test/rv_id_tb.sv

// ==== test/rv_id_stimulus.mem ====
// pc inst reg1_data reg2_data | ex: wreg waddr wdata aluop | mem: wreg waddr wdata
// expect: stall aluop alusel wreg waddr operand1 operand2 inst_valid
00000100_ffd30293_0a0a0a0a_0b0b0b0b_0_00_00000000_00_0_00_00000000_0_01_3_1_05_0a0a0a0a_fffffffd_1
00000104_0ff44393_0a0a0a0a_0b0b0b0b_0_00_00000000_00_0_00_00000000_0_05_1_1_07_0a0a0a0a_000000ff_1
00000108_40455493_0a0a0a0a_0b0b0b0b_0_00_00000000_00_0_00_00000000_0_0a_2_1_09_0a0a0a0a_00000004_1
0000010c_40d605b3_0a0a0a0a_0b0b0b0b_0_00_00000000_00_0_00_00000000_0_02_3_1_0b_0a0a0a0a_0b0b0b0b_1
00000110_0107b733_0a0a0a0a_0b0b0b0b_0_00_00000000_00_0_00_00000000_0_04_4_1_0e_0a0a0a0a_0b0b0b0b_1
00000114_123458b7_0a0a0a0a_0b0b0b0b_0_00_00000000_00_0_00_00000000_0_0b_2_1_11_00000000_12345000_1
00000118_abcde917_0a0a0a0a_0b0b0b0b_0_00_00000000_00_0_00_00000000_0_01_3_1_12_00000118_abcde000_1
0000011c_008000ef_0a0a0a0a_0b0b0b0b_0_00_00000000_00_0_00_00000000_0_0c_5_1_01_00000000_00000000_1
00000120_000280e7_0a0a0a0a_0b0b0b0b_0_00_00000000_00_0_00_00000000_0_0d_5_1_01_0a0a0a0a_00000000_1
00000124_01012a03_0a0a0a0a_0b0b0b0b_0_00_00000000_00_0_00_00000000_0_16_6_1_14_0a0a0a0a_00000000_1
00000128_0151a423_0a0a0a0a_0b0b0b0b_0_00_00000000_00_0_00_00000000_0_1b_7_0_00_0a0a0a0a_0b0b0b0b_1
0000012c_00527863_0a0a0a0a_0b0b0b0b_0_00_00000000_00_0_00_00000000_0_13_0_0_00_0a0a0a0a_0b0b0b0b_1
00000130_00730b33_0a0a0a0a_0b0b0b0b_1_06_0000e0e0_01_1_06_0000d0d0_0_01_3_1_16_0000e0e0_0b0b0b0b_1
00000134_00730b33_0a0a0a0a_0b0b0b0b_1_09_0000e0e0_01_1_07_0000d0d0_0_01_3_1_16_0a0a0a0a_0000d0d0_1
00000138_00700b33_0a0a0a0a_0b0b0b0b_1_00_0000e0e0_01_0_00_00000000_0_01_3_1_16_00000000_0b0b0b0b_1
0000013c_00730b33_0a0a0a0a_0b0b0b0b_1_07_0000e0e0_16_0_00_00000000_1_00_0_0_00_00000000_00000000_0
00000140_00730b33_0a0a0a0a_0b0b0b0b_1_07_0000e0e0_01_0_00_00000000_0_01_3_1_16_0a0a0a0a_0000e0e0_1
00000144_027302b3_0a0a0a0a_0b0b0b0b_0_00_00000000_00_0_00_00000000_0_00_0_0_00_00000000_00000000_0
00000148_300312f3_0a0a0a0a_0b0b0b0b_0_00_00000000_00_0_00_00000000_0_00_0_0_00_00000000_00000000_0
0000014c_0ff0000f_0a0a0a0a_0b0b0b0b_0_00_00000000_00_0_00_00000000_0_00_0_0_00_00000000_00000000_0
00000150_0000007f_0a0a0a0a_0b0b0b0b_0_00_00000000_00_0_00_00000000_0_00_0_0_00_00000000_00000000_0
